//--- all.f
+incdir+include
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_store_port.sv
hw/rv_core.sv
verif/rv_core_tb.sv

//--- hw/rv_alu.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_alu import rv_pkg::*; (
    input  ctrl_t               ctrl_i,
    input  logic [`RV_XLEN-1:0] pc_i,
    input  logic [`RV_XLEN-1:0] pc_plus4_i,
    input  logic [`RV_XLEN-1:0] rs1_data_i,
    input  logic [`RV_XLEN-1:0] rs2_data_i,
    input  logic [`RV_XLEN-1:0] imm_i,
    output logic [`RV_XLEN-1:0] result_o,
    output logic [`RV_XLEN-1:0] wb_data_o,
    output logic                branch_taken_o
);

    logic [`RV_XLEN-1:0] op1;
    logic [`RV_XLEN-1:0] op2;
    logic [4:0]          shamt;

    assign op1   = ctrl_i.op1_is_pc ? pc_i : rs1_data_i;
    assign op2   = ctrl_i.op2_is_reg ? rs2_data_i : imm_i;
    assign shamt = op2[4:0];

    // --------------------------------------------------
    // Datapath
    // --------------------------------------------------
    always_comb begin
        case (ctrl_i.alu_op)
            ALU_SLL:  result_o = op1 << shamt;
            ALU_SRL:  result_o = op1 >> shamt;
            ALU_SRA:  result_o = $signed(op1) >>> shamt;
            ALU_ADD:  result_o = op1 + op2;
            ALU_SUB:  result_o = op1 - op2;
            ALU_AND:  result_o = op1 & op2;
            ALU_OR:   result_o = op1 | op2;
            ALU_XOR:  result_o = op1 ^ op2;
            ALU_SLTU: result_o = {{(`RV_XLEN-1){1'b0}}, op1 < op2};
            ALU_SLT:  result_o = {{(`RV_XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            // LUI lands here with the U immediate
            default:  result_o = op2;
        endcase
    end

    // Link address for JAL and JALR
    assign wb_data_o = ctrl_i.wb_is_link ? pc_plus4_i : result_o;

    // --------------------------------------------------
    // Branch compare
    // --------------------------------------------------
    always_comb begin
        branch_taken_o = 1'b0;
        if (ctrl_i.is_branch) begin
            case (ctrl_i.funct3)
                3'b000:  branch_taken_o = (rs1_data_i == rs2_data_i);
                3'b001:  branch_taken_o = (rs1_data_i != rs2_data_i);
                3'b100:  branch_taken_o = ($signed(rs1_data_i) < $signed(rs2_data_i));
                3'b101:  branch_taken_o = ($signed(rs1_data_i) >= $signed(rs2_data_i));
                3'b110:  branch_taken_o = (rs1_data_i < rs2_data_i);
                3'b111:  branch_taken_o = (rs1_data_i >= rs2_data_i);
                default: branch_taken_o = 1'b0;
            endcase
        end
    end

endmodule

//--- hw/rv_core.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_core import rv_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic [31:0]         inst_i,
    input  logic                credit_i,
    output logic [`RV_XLEN-1:0] inst_addr_o,
    output logic                store_valid_o,
    output store_req_t          store_o
);

    ctrl_t               ctrl;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] result;
    logic [`RV_XLEN-1:0] wb_data;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [4:0]          rd;
    logic                branch_taken;
    logic                stall;

    // --------------------------------------------------
    // Fetch
    // --------------------------------------------------
    rv_fetch u_fetch (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .stall_i    (stall),
        .pc_sel_i   (ctrl.pc_sel),
        .imm_i      (imm),
        .rs1_data_i (rs1_data),
        .pc_o       (pc),
        .pc_plus4_o (pc_plus4)
    );

    assign inst_addr_o = pc;

    // --------------------------------------------------
    // Decode, registers, execute
    // --------------------------------------------------
    rv_decode u_decode (
        .inst_i         (inst_i),
        .branch_taken_i (branch_taken),
        .ctrl_o         (ctrl),
        .imm_o          (imm),
        .rs1_o          (rs1),
        .rs2_o          (rs2),
        .rd_o           (rd)
    );

    rv_regfile u_regfile (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rd_i       (rd),
        .we_i       (ctrl.reg_write),
        .stall_i    (stall),
        .wd_i       (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    rv_alu u_alu (
        .ctrl_i         (ctrl),
        .pc_i           (pc),
        .pc_plus4_i     (pc_plus4),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .imm_i          (imm),
        .result_o       (result),
        .wb_data_o      (wb_data),
        .branch_taken_o (branch_taken)
    );

    // --------------------------------------------------
    // Store port
    // --------------------------------------------------
    rv_store_port u_store_port (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .is_store_i    (ctrl.is_store),
        .funct3_i      (ctrl.funct3),
        .addr_i        (result),
        .data_i        (rs2_data),
        .credit_i      (credit_i),
        .stall_o       (stall),
        .store_valid_o (store_valid_o),
        .store_o       (store_o)
    );

endmodule

//--- hw/rv_decode.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_decode import rv_pkg::*; (
    input  logic [31:0]         inst_i,
    input  logic                branch_taken_i,
    output ctrl_t               ctrl_o,
    output logic [`RV_XLEN-1:0] imm_o,
    output logic [4:0]          rs1_o,
    output logic [4:0]          rs2_o,
    output logic [4:0]          rd_o
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7_alt;
    imm_sel_e   imm_sel;
    ctrl_t      ctrl;

    logic [`RV_XLEN-1:0] imm_i_type;
    logic [`RV_XLEN-1:0] imm_s_type;
    logic [`RV_XLEN-1:0] imm_u_type;
    logic [`RV_XLEN-1:0] imm_b_type;
    logic [`RV_XLEN-1:0] imm_j_type;

    // --------------------------------------------------
    // Fields
    // --------------------------------------------------
    assign opcode     = opcode_e'(inst_i[6:0]);
    assign rd_o       = inst_i[11:7];
    assign funct3     = inst_i[14:12];
    assign rs1_o      = inst_i[19:15];
    assign rs2_o      = inst_i[24:20];
    // SUB and SRA/SRAI
    assign funct7_alt = inst_i[30];

    // --------------------------------------------------
    // Immediates
    // --------------------------------------------------
    assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s_type = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_u_type = {inst_i[31:12], 12'b0};
    assign imm_b_type = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                         inst_i[11:8], 1'b0};
    assign imm_j_type = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                         inst_i[30:21], 1'b0};

    always_comb begin
        case (imm_sel)
            IMM_S:   imm_o = imm_s_type;
            IMM_U:   imm_o = imm_u_type;
            IMM_BJ:  imm_o = (opcode == OP_JAL) ? imm_j_type : imm_b_type;
            default: imm_o = imm_i_type;
        endcase
    end

    // --------------------------------------------------
    // Control
    // --------------------------------------------------
    always_comb begin
        ctrl        = '0;
        ctrl.pc_sel = PC_PLUS4;
        ctrl.alu_op = ALU_NONE;
        ctrl.funct3 = funct3;
        imm_sel     = IMM_I;

        case (opcode)
            OP_LUI: begin
                imm_sel        = IMM_U;
                ctrl.reg_write = 1'b1;
            end
            OP_AUIPC: begin
                imm_sel        = IMM_U;
                ctrl.op1_is_pc = 1'b1;
                ctrl.alu_op    = ALU_ADD;
                ctrl.reg_write = 1'b1;
            end
            OP_JAL: begin
                imm_sel         = IMM_BJ;
                ctrl.pc_sel     = PC_JAL;
                ctrl.reg_write  = 1'b1;
                ctrl.wb_is_link = 1'b1;
            end
            OP_JALR: begin
                ctrl.pc_sel     = PC_JALR;
                ctrl.reg_write  = 1'b1;
                ctrl.wb_is_link = 1'b1;
            end
            OP_BRANCH: begin
                imm_sel        = IMM_BJ;
                ctrl.is_branch = 1'b1;
                ctrl.pc_sel    = branch_taken_i ? PC_BRANCH : PC_PLUS4;
            end
            OP_STORE: begin
                imm_sel       = IMM_S;
                ctrl.alu_op   = ALU_ADD;
                ctrl.is_store = 1'b1;
            end
            OP_IMM, OP_REG: begin
                ctrl.op2_is_reg = (opcode == OP_REG);
                ctrl.reg_write  = 1'b1;
                case (funct3)
                    3'b000: begin
                        ctrl.alu_op = (opcode == OP_REG && funct7_alt) ? ALU_SUB : ALU_ADD;
                    end
                    3'b001:  ctrl.alu_op = ALU_SLL;
                    3'b010:  ctrl.alu_op = ALU_SLT;
                    3'b011:  ctrl.alu_op = ALU_SLTU;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    3'b101:  ctrl.alu_op = funct7_alt ? ALU_SRA : ALU_SRL;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    default: ctrl.alu_op = ALU_AND;
                endcase
            end
            // Anything else retires as a no-op
            default: begin
                ctrl.reg_write = 1'b0;
            end
        endcase
    end

    assign ctrl_o = ctrl;

endmodule

//--- hw/rv_fetch.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_fetch import rv_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                stall_i,
    input  pc_sel_e             pc_sel_i,
    input  logic [`RV_XLEN-1:0] imm_i,
    input  logic [`RV_XLEN-1:0] rs1_data_i,
    output logic [`RV_XLEN-1:0] pc_o,
    output logic [`RV_XLEN-1:0] pc_plus4_o
);

    logic [`RV_XLEN-1:0] pc_q;
    logic [`RV_XLEN-1:0] pc_d;
    logic [`RV_XLEN-1:0] jalr_sum;

    assign pc_plus4_o = pc_q + `RV_XLEN'd4;
    assign jalr_sum   = rs1_data_i + imm_i;

    // JAL and taken branches share PC-relative target
    always_comb begin
        case (pc_sel_i)
            PC_JAL, PC_BRANCH: pc_d = pc_q + imm_i;
            PC_JALR:           pc_d = {jalr_sum[`RV_XLEN-1:1], 1'b0};
            default:           pc_d = pc_plus4_o;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q <= `RV_RESET_PC;
        end else if (!stall_i) begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

    // Catches jump targets that land on a half-word
    a_pc_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
        pc_q[1:0] == 2'b00);

endmodule

//--- hw/rv_pkg.sv
`include "rv_cfg.svh"

package rv_pkg;

    // --------------------------------------------------
    // Encodings
    // --------------------------------------------------
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    // ALU_NONE passes operand 2 through
    typedef enum logic [3:0] {
        ALU_NONE = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SRL  = 4'b0010,
        ALU_SRA  = 4'b0011,
        ALU_ADD  = 4'b0100,
        ALU_SUB  = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_OR   = 4'b1000,
        ALU_XOR  = 4'b1001,
        ALU_SLTU = 4'b1010,
        ALU_SLT  = 4'b1011
    } alu_op_e;

    typedef enum logic [1:0] {
        PC_PLUS4  = 2'd0,
        PC_JAL    = 2'd1,
        PC_JALR   = 2'd2,
        PC_BRANCH = 2'd3
    } pc_sel_e;

    typedef enum logic [1:0] {
        IMM_I  = 2'd0,
        IMM_S  = 2'd1,
        IMM_U  = 2'd2,
        IMM_BJ = 2'd3
    } imm_sel_e;

    // --------------------------------------------------
    // Bundles
    // --------------------------------------------------
    typedef struct packed {
        pc_sel_e    pc_sel;
        alu_op_e    alu_op;
        logic       op1_is_pc;
        logic       op2_is_reg;
        logic       reg_write;
        logic       wb_is_link;
        logic       is_store;
        logic       is_branch;
        logic [2:0] funct3;
    } ctrl_t;

    // Width code: 00 word, 01 half, 11 byte
    typedef struct packed {
        logic [`RV_XLEN-1:0] addr;
        logic [`RV_XLEN-1:0] data;
        logic [1:0]          width;
    } store_req_t;

endpackage

//--- hw/rv_regfile.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_regfile (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic [4:0]          rs1_i,
    input  logic [4:0]          rs2_i,
    input  logic [4:0]          rd_i,
    input  logic                we_i,
    input  logic                stall_i,
    input  logic [`RV_XLEN-1:0] wd_i,
    output logic [`RV_XLEN-1:0] rs1_data_o,
    output logic [`RV_XLEN-1:0] rs2_data_o
);

    // x0 has no storage
    logic [`RV_XLEN-1:0] regs_q [1:`RV_REGS-1];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 1; i < `RV_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && !stall_i && rd_i != 5'd0) begin
            regs_q[rd_i] <= wd_i;
        end
    end

    assign rs1_data_o = (rs1_i == 5'd0) ? '0 : regs_q[rs1_i];
    assign rs2_data_o = (rs2_i == 5'd0) ? '0 : regs_q[rs2_i];

endmodule

//--- hw/rv_store_port.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_store_port import rv_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                is_store_i,
    input  logic [2:0]          funct3_i,
    input  logic [`RV_XLEN-1:0] addr_i,
    input  logic [`RV_XLEN-1:0] data_i,
    input  logic                credit_i,
    output logic                stall_o,
    output logic                store_valid_o,
    output store_req_t          store_o
);

    localparam int CNT_W = $clog2(`RV_STORE_CREDITS + 1);

    logic [CNT_W-1:0] credit_cnt_q;
    logic             issue;
    logic [1:0]       width;
    store_req_t       store_q;

    // A credit returning this cycle can be spent at the same edge
    assign stall_o = is_store_i && (credit_cnt_q == '0) && !credit_i;
    assign issue   = is_store_i && !stall_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            credit_cnt_q  <= CNT_W'(`RV_STORE_CREDITS);
            store_valid_o <= 1'b0;
        end else begin
            credit_cnt_q  <= credit_cnt_q - CNT_W'(issue) + CNT_W'(credit_i);
            store_valid_o <= issue;
        end
    end

    always_comb begin
        case (funct3_i)
            3'b000:  width = 2'b11;
            3'b001:  width = 2'b01;
            default: width = 2'b00;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (issue) begin
            store_q <= '{addr: addr_i, data: data_i, width: width};
        end
    end

    assign store_o = store_q;

    // Environment must not return more credits than it was given
    a_credit_max: assert property (@(posedge clk_i) disable iff (rst_i)
        credit_cnt_q <= CNT_W'(`RV_STORE_CREDITS));

endmodule

//--- include/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Data and address width
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_REGS 32

// Credits held by the store port after reset
`define RV_STORE_CREDITS 2

`define RV_RESET_PC 32'h0000_0000

`endif

//--- verif/rv_core_tb.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_core_tb import rv_pkg::*; ();

    localparam int NT        = 9;
    localparam int MAX_DELAY = 8;
    localparam int TAIL      = 4;

    logic                clk_i;
    logic                rst_i;
    logic [31:0]         inst_i;
    logic                credit_i;
    logic [`RV_XLEN-1:0] inst_addr_o;
    logic                store_valid_o;
    store_req_t          store_o;

    logic [31:0] mem [64];

    // Test table
    string       name [NT];
    logic [31:0] prog [NT][12];
    int          n_prog [NT];
    store_req_t  exp_st [NT][8];
    int          n_exp [NT];
    logic [31:0] trace_exp [NT][12];
    int          n_trace [NT];
    bit          withheld [NT];

    // Run state
    int          cycles;
    int          outstanding;
    int          n_store;
    int          test_errs;
    int          total_errs;
    int          tests_failed;
    int          due_q [$];
    logic [31:0] trace_seen [12];
    int          n_seen;
    bit          hold_pending;
    logic [31:0] hold_addr;

    rv_core UUT (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .inst_i        (inst_i),
        .credit_i      (credit_i),
        .inst_addr_o   (inst_addr_o),
        .store_valid_o (store_valid_o),
        .store_o       (store_o)
    );

    assign inst_i = mem[inst_addr_o[7:2]];

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // Instruction encoders
    // --------------------------------------------------
    function automatic logic [31:0] enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3,
                                          int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, int rs1, logic [2:0] f3, int rd,
                                          logic [6:0] op);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, int rs2, int rs1, logic [2:0] f3);
        return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, int rs2, int rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'b1101111};
    endfunction

    // addi x0,x0,imm with the immediate folded from the full address
    function automatic logic [31:0] fill_word(logic [31:0] a);
        logic [11:0] imm;
        imm = a[11:0] ^ a[23:12] ^ {4'b0, a[31:24]};
        return {imm, 20'h00013};
    endfunction

    task automatic add_inst(int t, logic [31:0] w);
        prog[t][n_prog[t]] = w;
        n_prog[t]++;
    endtask

    task automatic add_store(int t, logic [31:0] a, logic [31:0] d, logic [1:0] w);
        exp_st[t][n_exp[t]] = {a, d, w};
        n_exp[t]++;
    endtask

    task automatic add_trace(int t, logic [31:0] a);
        trace_exp[t][n_trace[t]] = a;
        n_trace[t]++;
    endtask

    // --------------------------------------------------
    // Test table
    // --------------------------------------------------
    task automatic build_table();
        for (int t = 0; t < NT; t++) begin
            n_prog[t]  = 0;
            n_exp[t]   = 0;
            n_trace[t] = 0;
        end
        name[0] = "alu"; withheld[0] = 0;
        add_inst(0, enc_i(-12'sd5, 0, 3'b000, 1, 7'b0010011));
        add_inst(0, enc_i(12'd7, 0, 3'b000, 2, 7'b0010011));
        add_inst(0, enc_r(7'h20, 2, 1, 3'b000, 3));
        add_inst(0, enc_r(7'h00, 2, 1, 3'b010, 4));
        add_inst(0, enc_r(7'h00, 2, 1, 3'b011, 5));
        add_inst(0, enc_s(12'h100, 3, 0, 3'b010));
        add_inst(0, enc_s(12'h104, 4, 0, 3'b010));
        add_inst(0, enc_s(12'h108, 5, 0, 3'b010));
        add_inst(0, enc_r(7'h00, 2, 1, 3'b111, 6));
        add_inst(0, enc_r(7'h00, 2, 1, 3'b110, 7));
        add_inst(0, enc_s(12'h10c, 6, 0, 3'b010));
        add_inst(0, enc_s(12'h110, 7, 0, 3'b010));
        add_store(0, 32'h100, 32'hffff_fff4, 2'b00);
        add_store(0, 32'h104, 32'h1, 2'b00);
        add_store(0, 32'h108, 32'h0, 2'b00);
        add_store(0, 32'h10c, 32'h3, 2'b00);
        add_store(0, 32'h110, 32'hffff_ffff, 2'b00);

        name[1] = "shift"; withheld[1] = 1;
        add_inst(1, enc_i(-12'sd16, 0, 3'b000, 1, 7'b0010011));
        add_inst(1, enc_i(12'd3, 0, 3'b000, 2, 7'b0010011));
        add_inst(1, enc_i(12'h004, 1, 3'b001, 3, 7'b0010011));
        add_inst(1, enc_i(12'h004, 1, 3'b101, 4, 7'b0010011));
        add_inst(1, enc_i(12'h404, 1, 3'b101, 5, 7'b0010011));
        add_inst(1, enc_r(7'h00, 2, 1, 3'b101, 6));
        add_inst(1, enc_r(7'h20, 2, 1, 3'b101, 7));
        for (int k = 0; k < 5; k++) begin
            add_inst(1, enc_s(12'h100 + 12'(4 * k), 3 + k, 0, 3'b010));
        end
        add_store(1, 32'h100, 32'hffff_ff00, 2'b00);
        add_store(1, 32'h104, 32'h0fff_ffff, 2'b00);
        add_store(1, 32'h108, 32'hffff_ffff, 2'b00);
        add_store(1, 32'h10c, 32'h1fff_fffe, 2'b00);
        add_store(1, 32'h110, 32'hffff_fffe, 2'b00);

        name[2] = "jump"; withheld[2] = 0;
        add_inst(2, {20'h12345, 5'd1, 7'b0110111});
        add_inst(2, {20'h00001, 5'd2, 7'b0010111});
        add_inst(2, enc_j(21'd12, 3));
        add_inst(2, enc_s(12'h1f0, 0, 0, 3'b010));
        add_inst(2, enc_s(12'h1f0, 0, 0, 3'b010));
        add_inst(2, enc_i(12'd16, 3, 3'b000, 4, 7'b1100111));
        add_inst(2, enc_s(12'h1f4, 0, 0, 3'b010));
        for (int k = 0; k < 4; k++) begin
            add_inst(2, enc_s(12'h100 + 12'(4 * k), 1 + k, 0, 3'b010));
        end
        add_store(2, 32'h100, 32'h1234_5000, 2'b00);
        add_store(2, 32'h104, 32'h0000_1004, 2'b00);
        add_store(2, 32'h108, 32'h0000_000c, 2'b00);
        add_store(2, 32'h10c, 32'h0000_0018, 2'b00);
        for (int i = 0; i < 8; i++) begin
            add_trace(2, (i < 3) ? 32'(4 * i) : ((i == 3) ? 32'h14 : 32'(4 * i + 12)));
        end

        // Each branch skips the marker store that follows it when taken
        name[3] = "branch_a"; withheld[3] = 0;
        add_inst(3, enc_i(-12'sd1, 0, 3'b000, 1, 7'b0010011));
        add_inst(3, enc_b(13'd8, 0, 1, 3'b001));
        add_inst(3, enc_s(12'h100, 1, 0, 3'b010));
        add_inst(3, enc_b(13'd8, 0, 1, 3'b100));
        add_inst(3, enc_s(12'h104, 1, 0, 3'b010));
        add_inst(3, enc_b(13'd8, 0, 1, 3'b000));
        add_inst(3, enc_s(12'h108, 1, 0, 3'b010));
        add_inst(3, enc_b(13'd8, 0, 1, 3'b101));
        add_inst(3, enc_s(12'h10c, 1, 0, 3'b010));
        add_inst(3, enc_b(13'd8, 0, 1, 3'b110));
        add_inst(3, enc_s(12'h110, 1, 0, 3'b010));
        add_store(3, 32'h108, 32'hffff_ffff, 2'b00);
        add_store(3, 32'h10c, 32'hffff_ffff, 2'b00);
        add_store(3, 32'h110, 32'hffff_ffff, 2'b00);

        name[4] = "branch_b"; withheld[4] = 0;
        add_inst(4, enc_i(12'd1, 0, 3'b000, 1, 7'b0010011));
        add_inst(4, enc_b(13'd8, 0, 0, 3'b000));
        add_inst(4, enc_s(12'h100, 1, 0, 3'b010));
        add_inst(4, enc_b(13'd8, 0, 0, 3'b001));
        add_inst(4, enc_s(12'h104, 1, 0, 3'b010));
        add_inst(4, enc_b(13'd8, 0, 1, 3'b101));
        add_inst(4, enc_s(12'h108, 1, 0, 3'b010));
        add_inst(4, enc_b(13'd8, 1, 0, 3'b110));
        add_inst(4, enc_s(12'h10c, 1, 0, 3'b010));
        add_inst(4, enc_b(13'd8, 1, 0, 3'b111));
        add_inst(4, enc_s(12'h110, 1, 0, 3'b010));
        add_store(4, 32'h104, 32'h1, 2'b00);
        add_store(4, 32'h110, 32'h1, 2'b00);

        name[5] = "branch_c"; withheld[5] = 0;
        add_inst(5, enc_i(12'd1, 0, 3'b000, 1, 7'b0010011));
        add_inst(5, enc_b(13'd8, 0, 1, 3'b100));
        add_inst(5, enc_s(12'h100, 1, 0, 3'b010));
        add_inst(5, enc_b(13'd8, 0, 1, 3'b111));
        add_inst(5, enc_s(12'h104, 1, 0, 3'b010));
        add_inst(5, enc_s(12'h108, 1, 0, 3'b010));
        add_store(5, 32'h100, 32'h1, 2'b00);
        add_store(5, 32'h108, 32'h1, 2'b00);

        name[6] = "width"; withheld[6] = 0;
        add_inst(6, enc_i(12'h200, 0, 3'b000, 1, 7'b0010011));
        add_inst(6, {20'h12345, 5'd2, 7'b0110111});
        add_inst(6, enc_i(12'h678, 2, 3'b000, 2, 7'b0010011));
        add_inst(6, enc_s(12'h001, 2, 1, 3'b000));
        add_inst(6, enc_s(12'hffe, 2, 1, 3'b001));
        add_inst(6, enc_s(12'h008, 2, 1, 3'b010));
        add_store(6, 32'h201, 32'h1234_5678, 2'b11);
        add_store(6, 32'h1fe, 32'h1234_5678, 2'b01);
        add_store(6, 32'h208, 32'h1234_5678, 2'b00);

        name[7] = "credit"; withheld[7] = 1;
        add_inst(7, enc_i(12'h011, 0, 3'b000, 1, 7'b0010011));
        for (int k = 0; k < 6; k++) begin
            add_inst(7, enc_s(12'h100 + 12'(4 * k), 1, 0, 3'b010));
            add_store(7, 32'h100 + 32'(4 * k), 32'h11, 2'b00);
        end
        for (int k = 0; k < 7; k++) begin
            add_trace(7, 32'(4 * k));
        end

        // SLTI, SLTIU, XORI, XOR and SLL with a register shift amount
        name[8] = "alu_imm"; withheld[8] = 0;
        add_inst(8, enc_i(-12'sd5, 0, 3'b000, 1, 7'b0010011));
        add_inst(8, enc_i(-12'sd8, 1, 3'b010, 2, 7'b0010011));
        add_inst(8, enc_i(-12'sd1, 1, 3'b011, 3, 7'b0010011));
        add_inst(8, enc_i(12'h0f0, 1, 3'b100, 4, 7'b0010011));
        add_inst(8, enc_r(7'h00, 4, 1, 3'b100, 5));
        add_inst(8, enc_r(7'h00, 3, 1, 3'b001, 6));
        for (int k = 0; k < 5; k++) begin
            add_inst(8, enc_s(12'h100 + 12'(4 * k), 2 + k, 0, 3'b010));
        end
        add_store(8, 32'h100, 32'h0, 2'b00);
        add_store(8, 32'h104, 32'h1, 2'b00);
        add_store(8, 32'h108, 32'hffff_ff0b, 2'b00);
        add_store(8, 32'h10c, 32'h0000_00f0, 2'b00);
        add_store(8, 32'h110, 32'hffff_fff6, 2'b00);
    endtask

    // --------------------------------------------------
    // Per-cycle bookkeeping, sampled mid-cycle
    // --------------------------------------------------
    task automatic sample_cycle(int t);
        int delay;
        if (n_seen < 12 && (n_seen == 0 || trace_seen[n_seen-1] !== inst_addr_o)) begin
            trace_seen[n_seen] = inst_addr_o;
            n_seen++;
        end
        if (hold_pending) begin
            assert (inst_addr_o === hold_addr) else begin
                $display("test %s: inst_addr_o moved from %h to %h on a stalled store",
                         name[t], hold_addr, inst_addr_o);
                test_errs++;
            end
        end
        if (store_valid_o) begin
            outstanding++;
            assert (outstanding <= `RV_STORE_CREDITS) else begin
                $display("test %s: %0d stores outstanding, more than the credits allow",
                         name[t], outstanding);
                test_errs++;
            end
            assert (n_store < n_exp[t]) else begin
                $display("test %s: unexpected extra store at %h", name[t], store_o.addr);
                test_errs++;
            end
            if (n_store < n_exp[t]) begin
                assert (store_o === exp_st[t][n_store]) else begin
                    $display("error %s store %0d expected %h/%h/%b actual %h/%h/%b",
                             name[t], n_store, exp_st[t][n_store].addr,
                             exp_st[t][n_store].data, exp_st[t][n_store].width,
                             store_o.addr, store_o.data, store_o.width);
                    test_errs++;
                end
            end
            n_store++;
            delay = withheld[t] ? 1 + int'($urandom % MAX_DELAY) : 1;
            due_q.push_back(cycles + delay);
        end
        hold_pending = (inst_i[6:0] == 7'b0100011) && !credit_i
                       && (outstanding == `RV_STORE_CREDITS);
        hold_addr    = inst_addr_o;
        if (credit_i) begin
            outstanding--;
        end
    endtask

    task automatic run_test(int t);
        int limit;
        int tail;
        repeat (8) begin
            @(posedge clk_i);
            rst_i    <= 1'b1;
            credit_i <= 1'b0;
        end
        // Core is held in reset while the program is swapped
        for (int i = 0; i < 64; i++) begin
            mem[i] = (i < n_prog[t]) ? prog[t][i] : fill_word(32'(4 * i));
        end
        @(posedge clk_i);
        rst_i <= 1'b0;
        due_q.delete();
        cycles       = 0;
        outstanding  = 0;
        n_store      = 0;
        n_seen       = 0;
        test_errs    = 0;
        hold_pending = 0;
        tail         = 0;
        limit        = 12 * (MAX_DELAY + 4) + 20;
        while (tail < TAIL && cycles < limit) begin
            @(negedge clk_i);
            sample_cycle(t);
            cycles++;
            if (n_store >= n_exp[t]) begin
                tail++;
            end
            @(posedge clk_i);
            if (due_q.size() > 0 && due_q[0] <= cycles) begin
                credit_i <= 1'b1;
                void'(due_q.pop_front());
            end else begin
                credit_i <= 1'b0;
            end
        end
        assert (n_store == n_exp[t]) else begin
            $display("error %s store count expected %0d actual %0d",
                     name[t], n_exp[t], n_store);
            test_errs++;
        end
        for (int i = 0; i < n_trace[t]; i++) begin
            assert (i < n_seen && trace_seen[i] === trace_exp[t][i]) else begin
                $display("error %s fetch %0d expected %h actual %h",
                         name[t], i, trace_exp[t][i], trace_seen[i]);
                test_errs++;
            end
        end
        $display("test %s: %s, %0d stores in %0d cycles", name[t],
                 (test_errs == 0) ? "ok" : "FAIL", n_store, cycles);
        total_errs += test_errs;
        if (test_errs != 0) begin
            tests_failed++;
        end
    endtask

    // --------------------------------------------------
    // Main sequence and watchdog
    // --------------------------------------------------
    initial begin
        rst_i        = 1'b1;
        credit_i     = 1'b0;
        total_errs   = 0;
        tests_failed = 0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = fill_word(32'(4 * i));
        end
        void'($urandom(32'hfc17084b));
        build_table();
        for (int t = 0; t < NT; t++) begin
            run_test(t);
        end
        $display("tests %0d, tests failing %0d, checks failing %0d",
                 NT, tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        int budget;
        #1;
        budget = 0;
        for (int t = 0; t < NT; t++) begin
            budget += n_prog[t] * (MAX_DELAY + 4) + 8 + 2 * TAIL + 20;
        end
        repeat (budget) @(posedge clk_i);
        $display("timeout: the run did not finish within %0d cycles", budget);
        $display("Testbench failed");
        $finish;
    end

endmodule
